//--- p4_meta.f
+incdir+.
p4_meta_pkg.sv
p4_reg_pkg.sv
p4_meta_regs.sv
p4_meta_ingress.sv
p4_meta_fifo.sv
p4_meta_egress.sv
p4_meta_top.sv
p4_meta_asserts.sv
tb_p4_meta.sv

//--- tb_p4_meta.sv
// testbench for the packet metadata path
//    packet table with expected metadata from the forwarding rules
//    lfsr driven egress ready, in-order scoreboard, typed compare tasks
//    overflow burst, disabled path, watchdog
`timescale 1ns/1ps
`include "p4_meta_defs.svh"
`default_nettype none

module tb_p4_meta;
   import p4_meta_pkg::*;
   import p4_reg_pkg::*;

   // buffer slots plus the egress output register
   localparam int KEEP_WORDS = `P4_META_FIFO_DEPTH + 1;

   typedef struct {
      string       name;
      port_t       tid;
      pid_t        pid;
      int          words;
      logic [31:0] map;
      logic [31:0] rss;
      logic        en;
      logic        burst;
      port_t       exp_port;
      logic        exp_rss_en;
      entropy_t    exp_entropy;
   } row_t;

   typedef struct {
      string    name;
      data_t    data;
      logic     sop;
      logic     eop;
      port_t    port;
      pid_t     pid;
      logic     rss_en;
      entropy_t entropy;
   } exp_word_t;

   logic       core_clk = 1'b0;
   logic       reset;
   timestamp_t timestamp;
   logic       in_valid;
   data_t      in_data;
   logic       in_sop;
   logic       in_eop;
   port_t      in_tid;
   pid_t       in_pid;
   logic       out_ready;
   logic       out_valid;
   data_t      out_data;
   logic       out_sop;
   logic       out_eop;
   port_t      out_tdest;
   pid_t       out_pid;
   logic       out_rss_enable;
   entropy_t   out_rss_entropy;
   logic       reg_wr;
   logic       reg_rd;
   reg_addr_t  reg_addr;
   logic [31:0] reg_wdata;
   logic [31:0] reg_rdata;

   row_t        rows [$];
   exp_word_t   exp_q [$];
   int          mismatches = 0;
   int          other_errors = 0;
   int          watchdog_cycles = 0;
   logic [31:0] lfsr;
   logic        hold_ready_low;
   data_t       next_data;
   logic [31:0] rdata;

   p4_meta_top i_p4_meta_top (
      .core_clk, .reset, .timestamp,
      .in_valid, .in_data, .in_sop, .in_eop, .in_tid, .in_pid,
      .out_ready, .out_valid, .out_data, .out_sop, .out_eop,
      .out_tdest, .out_pid, .out_rss_enable, .out_rss_entropy,
      .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata
   );

   always #2 core_clk = ~core_clk;

   // ----------------------------------------------------------------------------
   //  stimulus helpers
   // ----------------------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'hb4bcd35c) : (s >> 1);
   endfunction

   // ready gets one fresh lfsr bit per cycle unless held low
   always @(negedge core_clk) begin
      timestamp = timestamp + 1;
      if (hold_ready_low) begin
         out_ready = 1'b0;
      end else begin
         out_ready = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
   end

   task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
      @(negedge core_clk);
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(negedge core_clk);
      reg_wr    = 1'b0;
   endtask

   // read data is registered on the posedge between the two falling edges
   task automatic read_reg(input reg_addr_t addr, output logic [31:0] data);
      @(negedge core_clk);
      reg_rd   = 1'b1;
      reg_addr = addr;
      @(negedge core_clk);
      reg_rd   = 1'b0;
      data     = reg_rdata;
   endtask

   // expected metadata follows the forwarding and rss rules
   task automatic add_row(input string name, input port_t tid, input pid_t pid,
                          input int words, input logic [31:0] map, input logic [31:0] rss,
                          input logic en, input logic burst);
      row_t r;
      r = '{name, tid, pid, words, map, rss, en, burst, '0, 1'b0, '0};
      r.exp_port = port_t'(map >> (2 * tid));
      if (rss[17]) begin
         r.exp_rss_en  = rss[16];
         r.exp_entropy = rss[11:0];
      end else begin
         r.exp_rss_en  = 1'b1;
         r.exp_entropy = pid[11:0] ^ {10'b0, tid};
      end
      rows.push_back(r);
      watchdog_cycles += words * 8;
   endtask

   task automatic send_packet(input row_t r);
      exp_word_t e;
      e.name    = r.name;
      e.port    = r.exp_port;
      e.pid     = r.pid;
      e.rss_en  = r.exp_rss_en;
      e.entropy = r.exp_entropy;
      for (int w = 0; w < r.words; w++) begin
         @(negedge core_clk);
         in_valid = 1'b1;
         in_data  = next_data;
         in_sop   = (w == 0);
         in_eop   = (w == r.words - 1);
         // tid and pid only count on the sop word, later words carry other values
         in_tid   = (w == 0) ? r.tid : ~r.tid;
         in_pid   = (w == 0) ? r.pid : ~r.pid;
         // a burst keeps only what buffer and output register can hold
         if (r.en && (!r.burst || w < KEEP_WORDS)) begin
            e.data = next_data;
            e.sop  = in_sop;
            e.eop  = in_eop;
            exp_q.push_back(e);
         end
         next_data++;
      end
      @(negedge core_clk);
      in_valid = 1'b0;
      in_sop   = 1'b0;
      in_eop   = 1'b0;
   endtask

   // ----------------------------------------------------------------------------
   //  compare tasks
   // ----------------------------------------------------------------------------
   task automatic check_word(input string name, input data_t exp_data, input logic exp_sop,
                             input logic exp_eop, input data_t act_data, input logic act_sop,
                             input logic act_eop);
      if ({exp_data, exp_sop, exp_eop} !== {act_data, act_sop, act_eop}) begin
         $display("mismatch %s word: expected %h sop %b eop %b, actual %h sop %b eop %b",
                  name, exp_data, exp_sop, exp_eop, act_data, act_sop, act_eop);
         mismatches++;
      end
   endtask

   task automatic check_port(input string name, input port_t exp, input port_t act);
      if (exp !== act) begin
         $display("mismatch %s tdest: expected %0d actual %0d", name, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_pid(input string name, input pid_t exp, input pid_t act);
      if (exp !== act) begin
         $display("mismatch %s pid: expected %h actual %h", name, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_entropy(input string name, input entropy_t exp, input entropy_t act);
      if (exp !== act) begin
         $display("mismatch %s rss entropy: expected %h actual %h", name, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("mismatch %s: expected %b actual %b", name, exp, act);
         mismatches++;
      end
   endtask

   // ----------------------------------------------------------------------------
   //  egress monitor and scoreboard
   // ----------------------------------------------------------------------------
   always @(posedge core_clk) begin : monitor
      exp_word_t e;
      if (!reset && out_valid) begin
         if (exp_q.size() == 0) begin
            $display("error: output word %h appeared with no word expected", out_data);
            other_errors++;
         end else if (out_ready) begin
            e = exp_q.pop_front();
            check_word(e.name, e.data, e.sop, e.eop, out_data, out_sop, out_eop);
            check_port(e.name, e.port, out_tdest);
            check_pid(e.name, e.pid, out_pid);
            check_bit({e.name, " rss enable"}, e.rss_en, out_rss_enable);
            check_entropy(e.name, e.entropy, out_rss_entropy);
         end
      end
   end

   initial begin : watchdog
      // packet table and cycle budget are complete before reset drops
      @(negedge reset);
      repeat (watchdog_cycles) @(posedge core_clk);
      $display("error: timeout, egress output stalled after %0d cycles", watchdog_cycles);
      $display("TEST FAIL");
      $finish;
   end

   // ----------------------------------------------------------------------------
   //  main sequence
   // ----------------------------------------------------------------------------
   task automatic run_row(input row_t r);
      write_reg(reg_ctrl, {31'b0, r.en});
      write_reg(reg_port_map, r.map);
      write_reg(reg_rss, r.rss);
      hold_ready_low = r.burst;
      send_packet(r);
      if (r.burst) begin
         repeat (4) @(negedge core_clk);
         read_reg(reg_status, rdata);
         check_bit({r.name, " overflow set"}, 1'b1, rdata[0]);
         write_reg(reg_status, 32'h1);
         read_reg(reg_status, rdata);
         check_bit({r.name, " overflow cleared"}, 1'b0, rdata[0]);
         hold_ready_low = 1'b0;
      end
      // disabled path, give any stray word time to show up
      if (!r.en) begin
         repeat (16) @(negedge core_clk);
      end
      while (exp_q.size() != 0) @(negedge core_clk);
      repeat (4) @(negedge core_clk);
   endtask

   initial begin
      reset          = 1'b1;
      timestamp      = '0;
      in_valid       = 1'b0;
      in_data        = '0;
      in_sop         = 1'b0;
      in_eop         = 1'b0;
      in_tid         = '0;
      in_pid         = '0;
      out_ready      = 1'b0;
      reg_wr         = 1'b0;
      reg_rd         = 1'b0;
      reg_addr       = reg_ctrl;
      reg_wdata      = '0;
      lfsr           = 32'hf497177e;
      hold_ready_low = 1'b0;
      next_data      = '0;

      // map byte, entry i in bits 2i+1:2i
      add_row("identity_single", 2'd1, 16'h0123, 1, 32'he4, 32'h0, 1'b1, 1'b0);
      add_row("remap_multi", 2'd2, 16'hbeef, 5, 32'h1b, 32'h0, 1'b1, 1'b0);
      add_row("remap_tid3", 2'd3, 16'h5a5a, 4, 32'h4e, 32'h0, 1'b1, 1'b0);
      add_row("rss_override_off", 2'd0, 16'h0fff, 3, 32'h4e, 32'h2_0abc, 1'b1, 1'b0);
      add_row("rss_override_on", 2'd1, 16'h1234, 6, 32'h1b, 32'h3_0555, 1'b1, 1'b0);
      add_row("long_random", 2'd2, 16'hc3a5, 12, 32'he4, 32'h0, 1'b1, 1'b0);
      add_row("overflow_burst", 2'd3, 16'h7777, 20, 32'he4, 32'h0, 1'b1, 1'b1);
      add_row("disabled", 2'd0, 16'h0042, 4, 32'he4, 32'h0, 1'b0, 1'b0);
      add_row("after_enable", 2'd1, 16'h0101, 2, 32'h1b, 32'h0, 1'b1, 1'b0);
      watchdog_cycles += 200;

      repeat (5) @(negedge core_clk);
      reset = 1'b0;

      foreach (rows[i]) begin
         run_row(rows[i]);
      end

      // no drop outside the burst
      read_reg(reg_status, rdata);
      check_bit("final overflow status", 1'b0, rdata[0]);

      $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- p4_meta_asserts.sv
// concurrent checks on the metadata path, bound into the top level
//    egress word and metadata hold under back-pressure
//    egress idle through reset
//    a written word shows on the buffer read port next cycle
`timescale 1ns/1ps
`default_nettype none

module p4_meta_asserts (
   input wire logic                   core_clk,
   input wire logic                   reset,
   input wire logic                   out_ready,
   input wire logic                   out_valid,
   input wire p4_meta_pkg::data_t     out_data,
   input wire logic                   out_sop,
   input wire logic                   out_eop,
   input wire p4_meta_pkg::port_t     out_tdest,
   input wire p4_meta_pkg::pid_t      out_pid,
   input wire logic                   out_rss_enable,
   input wire p4_meta_pkg::entropy_t  out_rss_entropy,
   input wire logic                   wr_en,
   input wire logic                   rd_valid
);

   // ----------------------------------------------------------------------------
   //  egress stream
   // ----------------------------------------------------------------------------
   // stalled word and its metadata stay put until taken
   property hold_under_stall;
      @(posedge core_clk) disable iff (reset)
         (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_sop)
            && $stable(out_eop) && $stable(out_tdest) && $stable(out_pid)
            && $stable(out_rss_enable) && $stable(out_rss_entropy));
   endproperty

   assert property (hold_under_stall)
      else $error("egress outputs changed while stalled");

   // output slot empty once reset is seen
   assert property (@(posedge core_clk) reset |=> !out_valid)
      else $error("out_valid high during reset");

   // ----------------------------------------------------------------------------
   //  buffer read port
   // ----------------------------------------------------------------------------
   // written or dropped-on-full, the buffer holds a word afterwards
   assert property (@(posedge core_clk) disable iff (reset) wr_en |=> rd_valid)
      else $error("buffer did not show a written word");

endmodule

bind p4_meta_top p4_meta_asserts i_p4_meta_asserts (
   .core_clk, .reset, .out_ready, .out_valid, .out_data, .out_sop, .out_eop,
   .out_tdest, .out_pid, .out_rss_enable, .out_rss_entropy, .wr_en, .rd_valid
);

`default_nettype wire

//--- p4_meta_top.sv
// top level of the packet metadata path
//    register block, ingress producer, word buffer, egress consumer
`timescale 1ns/1ps
`default_nettype none

module p4_meta_top (
   input  wire logic                     core_clk,
   input  wire logic                     reset,
   input  wire p4_meta_pkg::timestamp_t  timestamp,
   // ingress stream, no stall
   input  wire logic                     in_valid,
   input  wire p4_meta_pkg::data_t       in_data,
   input  wire logic                     in_sop,
   input  wire logic                     in_eop,
   input  wire p4_meta_pkg::port_t       in_tid,
   input  wire p4_meta_pkg::pid_t        in_pid,
   // egress stream
   input  wire logic                     out_ready,
   output logic                          out_valid,
   output p4_meta_pkg::data_t            out_data,
   output logic                          out_sop,
   output logic                          out_eop,
   output p4_meta_pkg::port_t            out_tdest,
   output p4_meta_pkg::pid_t             out_pid,
   output logic                          out_rss_enable,
   output p4_meta_pkg::entropy_t         out_rss_entropy,
   // register strobes
   input  wire logic                     reg_wr,
   input  wire logic                     reg_rd,
   input  wire p4_reg_pkg::reg_addr_t    reg_addr,
   input  wire logic [31:0]              reg_wdata,
   output logic [31:0]                   reg_rdata
);
   import p4_meta_pkg::*;

   // register outputs
   logic                  enable;
   port_map_t             port_map;
   p4_reg_pkg::rss_ctrl_t rss_ctrl;

   // producer to buffer
   logic                  wr_en;
   data_t                 wr_data;
   logic                  wr_sop;
   logic                  wr_eop;
   user_metadata_t        wr_meta;

   // buffer to consumer
   logic                  rd_valid;
   data_t                 rd_data;
   logic                  rd_sop;
   logic                  rd_eop;
   user_metadata_t        rd_meta;
   logic                  rd_en;
   logic                  overflow_set;

   p4_meta_regs i_p4_meta_regs (
      .core_clk, .reset,
      .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata,
      .overflow_set,
      .enable, .port_map, .rss_ctrl
   );

   p4_meta_ingress i_p4_meta_ingress (
      .core_clk, .reset,
      .in_valid, .in_data, .in_sop, .in_eop, .in_tid, .in_pid,
      .timestamp, .enable, .port_map,
      .wr_en, .wr_data, .wr_sop, .wr_eop, .wr_meta
   );

   p4_meta_fifo i_p4_meta_fifo (
      .core_clk, .reset,
      .wr_en, .wr_data, .wr_sop, .wr_eop, .wr_meta,
      .rd_en,
      .rd_valid, .rd_data, .rd_sop, .rd_eop, .rd_meta,
      .overflow_set
   );

   p4_meta_egress i_p4_meta_egress (
      .core_clk, .reset,
      .rd_valid, .rd_data, .rd_sop, .rd_eop, .rd_meta,
      .rss_ctrl, .out_ready, .rd_en,
      .out_valid, .out_data, .out_sop, .out_eop,
      .out_tdest, .out_pid, .out_rss_enable, .out_rss_entropy
   );

endmodule

`default_nettype wire

//--- p4_meta_egress.sv
// egress consumer for the metadata path
//    output register loaded from the buffer under ready
//    per-packet metadata latch taken at sop
//    register controlled rss override
`timescale 1ns/1ps
`default_nettype none

module p4_meta_egress (
   input  wire logic                         core_clk,
   input  wire logic                         reset,
   input  wire logic                         rd_valid,
   input  wire p4_meta_pkg::data_t           rd_data,
   input  wire logic                         rd_sop,
   input  wire logic                         rd_eop,
   input  wire p4_meta_pkg::user_metadata_t  rd_meta,
   input  wire p4_reg_pkg::rss_ctrl_t        rss_ctrl,
   input  wire logic                         out_ready,
   output logic                              rd_en,
   output logic                              out_valid,
   output p4_meta_pkg::data_t                out_data,
   output logic                              out_sop,
   output logic                              out_eop,
   output p4_meta_pkg::port_t                out_tdest,
   output p4_meta_pkg::pid_t                 out_pid,
   output logic                              out_rss_enable,
   output p4_meta_pkg::entropy_t             out_rss_entropy
);
   import p4_meta_pkg::*;
   import p4_reg_pkg::*;

   // fields presented on every word of a packet
   typedef struct packed {
      port_t    tdest;
      pid_t     pid;
      logic     rss_enable;
      entropy_t rss_entropy;
   } egress_meta_t;

   egress_state_t state;
   egress_meta_t  meta_latch;
   logic          load;

   // refill when the output slot is empty or being taken this cycle
   assign load  = rd_valid && (!out_valid || out_ready);
   assign rd_en = load;

   // ----------------------------------------------------------------------------
   //  output word register
   // ----------------------------------------------------------------------------
   always_ff @(posedge core_clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge core_clk) begin
      if (load) begin
         out_data <= rd_data;
         out_sop  <= rd_sop;
         out_eop  <= rd_eop;
      end
   end

   // ----------------------------------------------------------------------------
   //  metadata latch, override applied once per packet
   // ----------------------------------------------------------------------------
   always_ff @(posedge core_clk) begin
      if (load && rd_sop) begin
         meta_latch.tdest <= rd_meta.egress_port;
         meta_latch.pid   <= rd_meta.pid;
         meta_latch.rss_enable  <= rss_ctrl.override ? rss_ctrl.enable : rd_meta.rss_enable;
         meta_latch.rss_entropy <= rss_ctrl.override ? rss_ctrl.entropy : rd_meta.rss_entropy;
      end
   end

   // latch changes only with a loaded sop word so fields hold under stall
   assign out_tdest       = meta_latch.tdest;
   assign out_pid         = meta_latch.pid;
   assign out_rss_enable  = meta_latch.rss_enable;
   assign out_rss_entropy = meta_latch.rss_entropy;

   // packet tracking, a stray non-sop word in idle keeps the old latch
   always_ff @(posedge core_clk) begin
      if (reset) begin
         state <= idle;
      end else if (load) begin
         case (state)
            idle:      if (rd_sop && !rd_eop) state <= in_packet;
            in_packet: if (rd_eop) state <= idle;
            default:   state <= idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- p4_meta_fifo.sv
// word and metadata buffer between producer and consumer
//    circular storage with show-ahead read port
//    occupancy count, drop on full with overflow pulse
`timescale 1ns/1ps
`include "p4_meta_defs.svh"
`default_nettype none

module p4_meta_fifo (
   input  wire logic                         core_clk,
   input  wire logic                         reset,
   input  wire logic                         wr_en,
   input  wire p4_meta_pkg::data_t           wr_data,
   input  wire logic                         wr_sop,
   input  wire logic                         wr_eop,
   input  wire p4_meta_pkg::user_metadata_t  wr_meta,
   input  wire logic                         rd_en,
   output logic                              rd_valid,
   output p4_meta_pkg::data_t                rd_data,
   output logic                              rd_sop,
   output logic                              rd_eop,
   output p4_meta_pkg::user_metadata_t       rd_meta,
   output logic                              overflow_set
);
   import p4_meta_pkg::*;

   localparam int DEPTH = `P4_META_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   // one buffer slot, word plus its packet record
   typedef struct packed {
      data_t          data;
      logic           sop;
      logic           eop;
      user_metadata_t meta;
   } entry_t;

   entry_t        mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          full;
   logic          wr_ok;
   logic          rd_ok;

   assign full  = (count == (AW+1)'(DEPTH));
   assign wr_ok = wr_en && !full;
   assign rd_ok = rd_en && rd_valid;

   // show-ahead, head slot is always on the read port
   assign rd_valid = (count != '0);
   assign rd_data  = mem[rd_ptr].data;
   assign rd_sop   = mem[rd_ptr].sop;
   assign rd_eop   = mem[rd_ptr].eop;
   assign rd_meta  = mem[rd_ptr].meta;

   always_ff @(posedge core_clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= '{data: wr_data, sop: wr_sop, eop: wr_eop, meta: wr_meta};
      end
   end

   // ----------------------------------------------------------------------------
   //  pointers, count, drop detect
   // ----------------------------------------------------------------------------
   always_ff @(posedge core_clk) begin
      if (reset) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         overflow_set <= 1'b0;
      end else begin
         // power-of-two depth, pointers wrap on their own
         if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
         count        <= count + (AW+1)'(wr_ok) - (AW+1)'(rd_ok);
         // one pulse per dropped word
         overflow_set <= wr_en && full;
      end
   end

endmodule

`default_nettype wire

//--- p4_meta_ingress.sv
// ingress producer for the metadata path
//    registers accepted stream words
//    builds the per-packet metadata record on sop words
//    port map lookup and rss entropy hash
`timescale 1ns/1ps
`default_nettype none

module p4_meta_ingress (
   input  wire logic                         core_clk,
   input  wire logic                         reset,
   input  wire logic                         in_valid,
   input  wire p4_meta_pkg::data_t           in_data,
   input  wire logic                         in_sop,
   input  wire logic                         in_eop,
   input  wire p4_meta_pkg::port_t           in_tid,
   input  wire p4_meta_pkg::pid_t            in_pid,
   input  wire p4_meta_pkg::timestamp_t      timestamp,
   input  wire logic                         enable,
   input  wire p4_meta_pkg::port_map_t       port_map,
   output logic                              wr_en,
   output p4_meta_pkg::data_t                wr_data,
   output logic                              wr_sop,
   output logic                              wr_eop,
   output p4_meta_pkg::user_metadata_t       wr_meta
);
   import p4_meta_pkg::*;

   user_metadata_t meta_new;
   logic           accept;

   // no stall on ingress, every valid word is taken unless disabled
   assign accept = in_valid && enable;

   // ----------------------------------------------------------------------------
   //  metadata for the packet starting on this word
   // ----------------------------------------------------------------------------
   always_comb begin
      meta_new.timestamp_ns = timestamp;
      meta_new.pid          = in_pid;
      meta_new.ingress_port = in_tid;
      // programmable forwarding in place of the p4 engine
      meta_new.egress_port  = port_map[in_tid];
      meta_new.rss_enable   = 1'b1;
      // simple hash, low pid bits folded with the source port
      meta_new.rss_entropy  = in_pid[11:0] ^ entropy_t'(in_tid);
   end

   // word valid, cleared by reset
   always_ff @(posedge core_clk) begin
      if (reset) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= accept;
      end
   end

   // ----------------------------------------------------------------------------
   //  word and record registers
   // ----------------------------------------------------------------------------
   always_ff @(posedge core_clk) begin
      if (accept) begin
         wr_data <= in_data;
         wr_sop  <= in_sop;
         wr_eop  <= in_eop;
         // mid-packet words keep the record of their packet
         if (in_sop) begin
            wr_meta <= meta_new;
         end
      end
   end

endmodule

`default_nettype wire

//--- p4_meta_regs.sv
// control and status registers on a plain strobe port
//    global enable, port map, rss override control
//    sticky overflow status, write 1 to clear
`timescale 1ns/1ps
`default_nettype none

module p4_meta_regs (
   input  wire logic                    core_clk,
   input  wire logic                    reset,
   input  wire logic                    reg_wr,
   input  wire logic                    reg_rd,
   input  wire p4_reg_pkg::reg_addr_t   reg_addr,
   input  wire logic [31:0]             reg_wdata,
   input  wire logic                    overflow_set,
   output logic [31:0]                  reg_rdata,
   output logic                         enable,
   output p4_meta_pkg::port_map_t       port_map,
   output p4_reg_pkg::rss_ctrl_t        rss_ctrl
);
   import p4_meta_pkg::*;
   import p4_reg_pkg::*;

   logic overflow;

   // ----------------------------------------------------------------------------
   //  write side
   // ----------------------------------------------------------------------------
   always_ff @(posedge core_clk) begin
      if (reset) begin
         enable   <= 1'b1;
         rss_ctrl <= '0;
         overflow <= 1'b0;
         // identity map, each port forwards to itself
         for (int i = 0; i < $size(port_map); i++) begin
            port_map[i] <= port_t'(i);
         end
      end else begin
         if (reg_wr) begin
            case (reg_addr)
               reg_ctrl:     enable   <= reg_wdata[0];
               reg_port_map: port_map <= reg_wdata[$bits(port_map_t)-1:0];
               reg_rss:      rss_ctrl <= '{override: reg_wdata[17],
                                           enable:   reg_wdata[16],
                                           entropy:  reg_wdata[11:0]};
               // w1c on the sticky flag
               reg_status:   if (reg_wdata[0]) overflow <= 1'b0;
               default: ;
            endcase
         end
         // a new drop wins over a clear in the same cycle
         if (overflow_set) begin
            overflow <= 1'b1;
         end
      end
   end

   // ----------------------------------------------------------------------------
   //  read side, one cycle latency, held until next read
   // ----------------------------------------------------------------------------
   always_ff @(posedge core_clk) begin
      if (reset) begin
         reg_rdata <= '0;
      end else if (reg_rd) begin
         case (reg_addr)
            reg_ctrl:     reg_rdata <= {31'b0, enable};
            reg_port_map: reg_rdata <= 32'(port_map);
            reg_rss:      reg_rdata <= {14'b0, rss_ctrl.override, rss_ctrl.enable,
                                        4'b0, rss_ctrl.entropy};
            reg_status:   reg_rdata <= {31'b0, overflow};
            // unmapped offsets read as zero
            default:      reg_rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- p4_reg_pkg.sv
// register map types for the metadata path
//    register address encoding
//    rss override control record
`default_nettype none

`include "p4_meta_defs.svh"

package p4_reg_pkg;

   // word addresses on the strobe register port
   typedef enum logic [`P4_REG_ADDR_W-1:0] {
      reg_ctrl     = `P4_REG_CTRL_ADDR,
      reg_port_map = `P4_REG_PORT_MAP_ADDR,
      reg_rss      = `P4_REG_RSS_ADDR,
      reg_status   = `P4_REG_STATUS_ADDR
   } reg_addr_t;

   // rss register, bit 17 override, bit 16 enable, bits 11:0 entropy
   typedef struct packed {
      logic                  override;
      logic                  enable;
      p4_meta_pkg::entropy_t entropy;
   } rss_ctrl_t;

endpackage

`default_nettype wire

//--- p4_meta_pkg.sv
// stream word and metadata types for the packet metadata path
//    timestamp, port, packet id and entropy fields
//    per-packet metadata record and port map array
//    egress FSM state encoding
`default_nettype none

`include "p4_meta_defs.svh"

package p4_meta_pkg;

   // one stream word
   typedef logic [`P4_META_DATA_W-1:0] data_t;

   // free-running nanosecond time from the shell
   typedef logic [63:0] timestamp_t;

   // switch port number, 4 ports
   typedef logic [$clog2(`P4_META_NUM_PORTS)-1:0] port_t;
   typedef logic [15:0] pid_t;
   typedef logic [11:0] entropy_t;

   // programmable ingress-to-egress port table, indexed by source port
   typedef port_t [`P4_META_NUM_PORTS-1:0] port_map_t;

   // record built once per packet at sop
   typedef struct packed {
      timestamp_t timestamp_ns;
      pid_t       pid;
      port_t      ingress_port;
      port_t      egress_port;
      logic       rss_enable;
      entropy_t   rss_entropy;
   } user_metadata_t;

   // egress packet tracking
   typedef enum logic {
      idle,
      in_packet
   } egress_state_t;

endpackage

`default_nettype wire

//--- p4_meta_defs.svh
// shared sizing macros for the metadata path
//    stream word width, switch port count, buffer depth
//    register address width and register offsets
`ifndef P4_META_DEFS_SVH
`define P4_META_DEFS_SVH

`default_nettype none

// ----------------------------------------------------------------------------
//  stream and buffer sizing
// ----------------------------------------------------------------------------
`define P4_META_DATA_W      64
`define P4_META_NUM_PORTS   4
`define P4_META_FIFO_DEPTH  16

// ----------------------------------------------------------------------------
//  register map, word offsets on the strobe port
// ----------------------------------------------------------------------------
`define P4_REG_ADDR_W       4
`define P4_REG_CTRL_ADDR    4'h0
`define P4_REG_PORT_MAP_ADDR 4'h1
`define P4_REG_RSS_ADDR     4'h2
`define P4_REG_STATUS_ADDR  4'h3

`default_nettype wire

`endif
